// File: bench/stim_mossbauer.txt
// run records in hex, one per line: channels sweeps selection clear gain
// gain is the count that every channel below channels picks up during the run
04 0002 0003 1 00000006
06 0001 000a 0 00000008
03 0002 0000 0 00000000
10 0001 0005 1 00000005
05 0003 0008 0 00000018
02 0001 0001 0 00000001
08 0002 0007 1 0000000e
01 0004 0009 0 00000020

// File: bench/tb_mossbauer.sv
`timescale 1ns/100ps

module tb_mossbauer;
  import mossbauer_pkg::*;

  localparam int NUM_CHANNELS = 16;
  localparam int BURST_LEN    = 8;
  localparam int MAX_RECORDS  = 32;
  localparam int REC_WORDS    = 5;     // channels, sweeps, selection, clear, gain per channel
  localparam int ACK_TIMEOUT  = 20;
  localparam int DONE_TIMEOUT = 4000;  // status polls

  logic     aclk;
  logic     areset_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  wb_data_t wb_dat_r;
  logic     wb_ack;
  logic     lower_threshold;
  logic     upper_threshold;

  wb_data_t stim_mem [MAX_RECORDS*REC_WORDS];
  count_t   ref_spectrum [NUM_CHANNELS];
  int       read_order [NUM_CHANNELS];
  integer   seed;

  mossbauer_spectrometer_top #(
    .LOWER_DURATION       (3),
    .UPPER_DURATION       (1),
    .IMPULSE_PAUSE        (4),
    .IMPULSES_PER_CHANNEL (BURST_LEN),
    .MAX_CHANNELS         (NUM_CHANNELS)
  ) UUT (
    .aclk            (aclk),
    .areset_n        (areset_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .lower_threshold (lower_threshold),
    .upper_threshold (upper_threshold)
  );

  initial
  begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_count(input string name, input count_t expected, input count_t actual);
    if (actual !== expected)
      report_failure($sformatf("Mismatch at time %0d ns: %s expected %0d, actual %0d",
                               $time, name, expected, actual));
  endtask

  task automatic check_status(input string name, input wb_data_t expected,
                              input wb_data_t actual);
    if (actual !== expected)
      report_failure($sformatf("Mismatch at time %0d ns: %s expected 0x%08h, actual 0x%08h",
                               $time, name, expected, actual));
  endtask

  task automatic bus_cycle(input logic write, input wb_addr_t addr, input wb_data_t data,
                           output wb_data_t rdata);
    int waited;
    waited = 0;
    @(posedge aclk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = write;
    wb_adr   = addr;
    wb_dat_w = data;
    @(posedge aclk);
    #1;
    while (!wb_ack)
    begin
      if (waited == ACK_TIMEOUT)
        report_failure("timeout while waiting for wb_ack");
      waited++;
      @(posedge aclk);
      #1;
    end
    if (waited != 0)
      report_failure("wb_ack did not come one cycle after wb_stb");
    rdata = wb_dat_r;
    @(posedge aclk);  // the slave samples its own ack here and ends the cycle
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
    wb_data_t ignored;
    bus_cycle(1'b1, addr, data, ignored);
  endtask

  task automatic bus_read(input wb_addr_t addr, output wb_data_t rdata);
    bus_cycle(1'b0, addr, '0, rdata);
  endtask

  task automatic check_spectrum();
    wb_data_t rdata;
    int       pick;
    int       swap;
    for (int i = 0; i < NUM_CHANNELS; i++)
      read_order[i] = i;
    for (int i = NUM_CHANNELS - 1; i > 0; i--)
    begin
      pick             = int'($unsigned($random(seed)) % (i + 1));
      swap             = read_order[i];
      read_order[i]    = read_order[pick];
      read_order[pick] = swap;
    end
    for (int i = 0; i < NUM_CHANNELS; i++)
    begin
      bus_read(wb_addr_t'(SPECTRUM_BASE + read_order[i]), rdata);
      check_count($sformatf("spectrum[%0d]", read_order[i]), ref_spectrum[read_order[i]],
                  count_t'(rdata));
    end
  endtask

  task automatic run_record(input int channels, input int sweeps, input int selection,
                            input int clear_flag, input int gain);
    wb_data_t rdata;
    int       polls;
    int       rule_gain;
    rule_gain = sweeps * ((selection < BURST_LEN) ? selection : BURST_LEN);
    if (rule_gain != gain)
      report_failure("a stim record disagrees with the spectrum count rule");
    bus_write(ADDR_SELECTION, wb_data_t'(selection));
    bus_write(ADDR_CHANNELS, wb_data_t'(channels));
    bus_write(ADDR_SWEEPS, wb_data_t'(sweeps));
    bus_read(ADDR_CHANNELS, rdata);
    check_status("channels readback", wb_data_t'(channels), rdata);
    bus_write(ADDR_CTRL, (clear_flag != 0) ? 32'h3 : 32'h1);
    bus_read(ADDR_STATUS, rdata);
    check_status("status while running", 32'h1, rdata);
    bus_write(ADDR_SELECTION, wb_data_t'(selection + 3));  // must be dropped while busy
    bus_read(ADDR_SELECTION, rdata);
    check_status("selection readback while busy", wb_data_t'(selection), rdata);
    polls = 0;
    rdata = '0;
    while (rdata[STATUS_DONE] !== 1'b1)
    begin
      if (polls == DONE_TIMEOUT)
        report_failure("timeout while waiting for STATUS_DONE");
      polls++;
      bus_read(ADDR_STATUS, rdata);
    end
    check_status("status after run", 32'h2, rdata);
    for (int n = 0; n < NUM_CHANNELS; n++)
    begin
      if (clear_flag != 0)
        ref_spectrum[n] = '0;
      if (n < channels)
        ref_spectrum[n] = ref_spectrum[n] + count_t'(gain);
    end
    check_spectrum();
  endtask

  // upper may only be high inside a lower pulse
  always @(negedge aclk)
  begin
    if (areset_n && upper_threshold && !lower_threshold)
      report_failure("upper_threshold was high while lower_threshold was low");
  end

  initial
  begin
    wb_data_t rdata;
    int       rec;
    seed     = 62312;
    areset_n = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    for (int i = 0; i < NUM_CHANNELS; i++)
      ref_spectrum[i] = '0;
    for (int i = 0; i < MAX_RECORDS*REC_WORDS; i++)
      stim_mem[i] = '0;
    $readmemh("bench/stim_mossbauer.txt", stim_mem);
    repeat (8) @(posedge aclk);
    #1;
    areset_n = 1'b1;
    bus_read(ADDR_STATUS, rdata);
    check_status("status after reset", 32'h0, rdata);
    check_spectrum();
    rec = 0;
    while (rec < MAX_RECORDS && stim_mem[rec*REC_WORDS] != '0)  // zero channels ends the list
    begin
      run_record(int'(stim_mem[rec*REC_WORDS]), int'(stim_mem[rec*REC_WORDS+1]),
                 int'(stim_mem[rec*REC_WORDS+2]), int'(stim_mem[rec*REC_WORDS+3]),
                 int'(stim_mem[rec*REC_WORDS+4]));
      rec++;
    end
    if (rec == 0)
      report_failure("no run records were found in the stim file");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: design/channel_sequencer.sv
`timescale 1ns/100ps

module channel_sequencer (
  input  logic                    aclk,
  input  logic                    areset_n,
  input  logic                    run_start,
  input  logic                    clear_req,
  input  logic                    clear_done,
  input  logic                    burst_done,
  input  mossbauer_pkg::channel_t channel_count,
  input  mossbauer_pkg::sweep_cnt_t sweep_count,
  output logic                    clear_start,
  output logic                    channel_start,
  output logic                    busy,
  output logic                    done,
  output mossbauer_pkg::channel_t channel_index
);
  import mossbauer_pkg::*;

  typedef enum logic [2:0] {
    idle,
    clearing,
    start_channel,
    wait_burst,
    finished
  } seq_state_t;

  seq_state_t state;
  sweep_cnt_t sweep_index;
  logic       last_channel;
  logic       last_sweep;

  assign last_channel = (channel_index == channel_count - channel_t'(1));
  assign last_sweep   = (sweep_index == sweep_count - sweep_cnt_t'(1));

  always_ff @(posedge aclk or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state         <= idle;
      sweep_index   <= '0;
      channel_index <= '0;
      clear_start   <= 1'b0;
      channel_start <= 1'b0;
      busy          <= 1'b0;
      done          <= 1'b0;
    end
    else
    begin
      clear_start   <= 1'b0;
      channel_start <= 1'b0;
      case (state)
        idle:
        begin
          if (run_start)
          begin
            busy          <= 1'b1;
            done          <= 1'b0;  // done holds until the next start
            channel_index <= '0;
            sweep_index   <= '0;
            if (clear_req)
            begin
              clear_start <= 1'b1;
              state       <= clearing;
            end
            else
              state <= start_channel;
          end
        end
        clearing:
        begin
          if (clear_done)
            state <= start_channel;
        end
        start_channel:
        begin
          if (channel_count == '0 || sweep_count == '0)
            state <= finished;  // nothing to visit
          else
          begin
            channel_start <= 1'b1;
            state         <= wait_burst;
          end
        end
        wait_burst:
        begin
          if (burst_done)
          begin
            if (!last_channel)
            begin
              channel_index <= channel_index + 1'b1;
              state         <= start_channel;
            end
            else if (!last_sweep)
            begin
              channel_index <= '0;
              sweep_index   <= sweep_index + 1'b1;
              state         <= start_channel;
            end
            else
              state <= finished;
          end
        end
        finished:
        begin
          busy  <= 1'b0;
          done  <= 1'b1;
          state <= idle;
        end
        default:
          state <= idle;
      endcase
    end
  end

  // a burst may only be launched inside a run
  a_start_in_run: assert property (
    @(posedge aclk) disable iff (!areset_n) channel_start |-> busy
  );

endmodule

// File: design/diff_discriminator.sv
`timescale 1ns/100ps

module diff_discriminator (
  input  logic aclk,
  input  logic areset_n,
  input  logic lower_threshold,
  input  logic upper_threshold,
  output logic count_event
);

  logic lower_q;
  logic upper_q;
  logic upper_seen;   // upper crossed during the current lower pulse
  logic lower_fall;
  logic rejected;

  assign lower_fall = lower_q && !lower_threshold;
  assign rejected   = upper_seen || upper_q;  // covers upper falling together with lower

  always_ff @(posedge aclk or negedge areset_n)
  begin
    if (!areset_n)
    begin
      lower_q     <= 1'b0;
      upper_q     <= 1'b0;
      upper_seen  <= 1'b0;
      count_event <= 1'b0;
    end
    else
    begin
      lower_q     <= lower_threshold;
      upper_q     <= upper_threshold;
      count_event <= lower_fall && !rejected;
      if (lower_fall)
        upper_seen <= 1'b0;
      else if (lower_q && upper_q)
        upper_seen <= 1'b1;
    end
  end

endmodule

// File: design/discriminator_signal_gen.sv
`timescale 1ns/100ps

module discriminator_signal_gen #(
  parameter int LOWER_DURATION       = 3,
  parameter int UPPER_DURATION       = 1,
  parameter int IMPULSE_PAUSE        = 4,
  parameter int IMPULSES_PER_CHANNEL = 8
) (
  input  logic                        aclk,
  input  logic                        areset_n,
  input  logic                        channel_start,
  input  mossbauer_pkg::impulse_cnt_t selection_count,
  output logic                        lower_threshold,
  output logic                        upper_threshold,
  output logic                        burst_done
);
  import mossbauer_pkg::*;

  typedef enum logic [2:0] {
    idle,
    lower_high,
    upper_high,
    upper_low,
    lower_low,
    pause
  } phase_t;

  phase_t       phase;
  impulse_cnt_t phase_cnt;     // cycles spent in the current pulse or gap
  impulse_cnt_t accepted_cnt;
  impulse_cnt_t total_cnt;
  logic         reject;        // current impulse gets an upper pulse
  logic         pulse_end;
  logic         gap_end;
  logic         last_impulse;
  logic         next_reject;

  assign pulse_end    = (phase_cnt == impulse_cnt_t'(LOWER_DURATION - 1));
  assign gap_end      = (phase_cnt == impulse_cnt_t'(IMPULSE_PAUSE - 1));
  assign last_impulse = (total_cnt == impulse_cnt_t'(IMPULSES_PER_CHANNEL - 1));
  assign next_reject  = (accepted_cnt >= selection_count);

  always_ff @(posedge aclk or negedge areset_n)
  begin
    if (!areset_n)
    begin
      phase           <= idle;
      phase_cnt       <= '0;
      accepted_cnt    <= '0;
      total_cnt       <= '0;
      reject          <= 1'b0;
      lower_threshold <= 1'b0;
      upper_threshold <= 1'b0;
      burst_done      <= 1'b0;
    end
    else
    begin
      burst_done <= 1'b0;
      case (phase)
        idle:
        begin
          if (channel_start)
          begin
            lower_threshold <= 1'b1;
            reject          <= next_reject;
            phase_cnt       <= '0;
            phase           <= lower_high;
          end
        end
        lower_high, upper_high, upper_low:
        begin
          phase_cnt <= phase_cnt + 1'b1;
          if (pulse_end)
          begin
            lower_threshold <= 1'b0;
            upper_threshold <= 1'b0;
            phase_cnt       <= '0;
            total_cnt       <= total_cnt + 1'b1;
            if (!reject)
              accepted_cnt <= accepted_cnt + 1'b1;
            phase <= last_impulse ? pause : lower_low;
          end
          else if (phase == lower_high && reject)
          begin
            upper_threshold <= 1'b1;  // one cycle after lower rose
            phase           <= upper_high;
          end
          else if (phase == upper_high && phase_cnt == impulse_cnt_t'(UPPER_DURATION))
          begin
            upper_threshold <= 1'b0;
            phase           <= upper_low;
          end
        end
        lower_low:
        begin
          phase_cnt <= phase_cnt + 1'b1;
          if (gap_end)
          begin
            lower_threshold <= 1'b1;
            reject          <= next_reject;
            phase_cnt       <= '0;
            phase           <= lower_high;
          end
        end
        pause:
        begin
          phase_cnt <= phase_cnt + 1'b1;
          if (gap_end)
          begin
            burst_done   <= 1'b1;  // the gap after the final impulse closes the burst
            accepted_cnt <= '0;
            total_cnt    <= '0;
            phase_cnt    <= '0;
            phase        <= idle;
          end
        end
        default:
          phase <= idle;
      endcase
    end
  end

  // upper sits inside the lower pulse
  a_upper_inside_lower: assert property (
    @(posedge aclk) disable iff (!areset_n) upper_threshold |-> lower_threshold
  );

endmodule

// File: design/mossbauer_pkg.sv
package mossbauer_pkg;

  // velocity channel index, up to 256 channels
  typedef logic [7:0] channel_t;

  typedef logic [31:0] count_t;        // one spectrum word per channel
  typedef logic [15:0] impulse_cnt_t;  // impulses or selection inside one burst
  typedef logic [15:0] sweep_cnt_t;

  typedef logic [31:0] wb_data_t;
  typedef logic [9:0]  wb_addr_t;      // word address

  // register map
  localparam wb_addr_t ADDR_CTRL      = 10'd0;
  localparam wb_addr_t ADDR_SELECTION = 10'd1;
  localparam wb_addr_t ADDR_CHANNELS  = 10'd2;
  localparam wb_addr_t ADDR_SWEEPS    = 10'd3;
  localparam wb_addr_t ADDR_STATUS    = 10'd4;
  localparam wb_addr_t SPECTRUM_BASE  = 10'd256;  // channel n sits at base plus n

  // control register bits
  localparam int CTRL_START = 0;
  localparam int CTRL_CLEAR = 1;

  // status register bits
  localparam int STATUS_BUSY = 0;
  localparam int STATUS_DONE = 1;

endpackage

// File: design/mossbauer_spectrometer_top.sv
`timescale 1ns/100ps

module mossbauer_spectrometer_top #(
  parameter int LOWER_DURATION       = 3,
  parameter int UPPER_DURATION       = 1,
  parameter int IMPULSE_PAUSE        = 4,
  parameter int IMPULSES_PER_CHANNEL = 8,
  parameter int MAX_CHANNELS         = 16
) (
  input  logic                    aclk,
  input  logic                    areset_n,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  mossbauer_pkg::wb_addr_t wb_adr,
  input  mossbauer_pkg::wb_data_t wb_dat_w,
  output mossbauer_pkg::wb_data_t wb_dat_r,
  output logic                    wb_ack,
  output logic                    lower_threshold,
  output logic                    upper_threshold
);
  import mossbauer_pkg::*;

  logic         run_start;
  logic         clear_req;
  logic         clear_start;
  logic         clear_done;
  logic         channel_start;
  logic         burst_done;
  logic         count_event;
  logic         busy;
  logic         done;
  impulse_cnt_t selection_count;
  channel_t     channel_count;
  sweep_cnt_t   sweep_count;
  channel_t     channel_index;
  channel_t     read_index;
  count_t       read_count;

  wb_spectrum_regs u_regs (
    .aclk            (aclk),
    .areset_n        (areset_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .busy            (busy),
    .done            (done),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .read_count      (read_count),
    .wb_ack          (wb_ack),
    .run_start       (run_start),
    .clear_req       (clear_req),
    .wb_dat_r        (wb_dat_r),
    .selection_count (selection_count),
    .channel_count   (channel_count),
    .sweep_count     (sweep_count),
    .read_index      (read_index)
  );

  channel_sequencer u_sequencer (
    .aclk          (aclk),
    .areset_n      (areset_n),
    .run_start     (run_start),
    .clear_req     (clear_req),
    .clear_done    (clear_done),
    .burst_done    (burst_done),
    .channel_count (channel_count),
    .sweep_count   (sweep_count),
    .clear_start   (clear_start),
    .channel_start (channel_start),
    .busy          (busy),
    .done          (done),
    .channel_index (channel_index)
  );

  discriminator_signal_gen #(
    .LOWER_DURATION       (LOWER_DURATION),
    .UPPER_DURATION       (UPPER_DURATION),
    .IMPULSE_PAUSE        (IMPULSE_PAUSE),
    .IMPULSES_PER_CHANNEL (IMPULSES_PER_CHANNEL)
  ) u_signal_gen (
    .aclk            (aclk),
    .areset_n        (areset_n),
    .channel_start   (channel_start),
    .selection_count (selection_count),
    .lower_threshold (lower_threshold),
    .upper_threshold (upper_threshold),
    .burst_done      (burst_done)
  );

  diff_discriminator u_discriminator (
    .aclk            (aclk),
    .areset_n        (areset_n),
    .lower_threshold (lower_threshold),
    .upper_threshold (upper_threshold),
    .count_event     (count_event)
  );

  spectrum_accumulator #(
    .MAX_CHANNELS (MAX_CHANNELS)
  ) u_accumulator (
    .aclk          (aclk),
    .areset_n      (areset_n),
    .count_event   (count_event),
    .clear_start   (clear_start),
    .channel_index (channel_index),
    .read_index    (read_index),
    .clear_done    (clear_done),
    .read_count    (read_count)
  );

endmodule

// File: design/spectrum_accumulator.sv
`timescale 1ns/100ps

module spectrum_accumulator #(
  parameter int MAX_CHANNELS = 16
) (
  input  logic                    aclk,
  input  logic                    areset_n,
  input  logic                    count_event,
  input  logic                    clear_start,
  input  mossbauer_pkg::channel_t channel_index,
  input  mossbauer_pkg::channel_t read_index,
  output logic                    clear_done,
  output mossbauer_pkg::count_t   read_count
);
  import mossbauer_pkg::*;

  localparam int ADDR_W = $clog2(MAX_CHANNELS);

  typedef logic [ADDR_W-1:0] mem_addr_t;

  count_t    mem [MAX_CHANNELS];
  mem_addr_t clear_addr;
  logic      clearing;
  logic      inc_pending;   // second half of the read-modify-write
  mem_addr_t inc_addr;
  count_t    inc_value;

  always_ff @(posedge aclk or negedge areset_n)
  begin
    if (!areset_n)
    begin
      clearing    <= 1'b0;
      clear_addr  <= '0;
      clear_done  <= 1'b0;
      inc_pending <= 1'b0;
    end
    else
    begin
      clear_done  <= 1'b0;
      inc_pending <= count_event;
      if (clear_start)
      begin
        clearing   <= 1'b1;
        clear_addr <= '0;
      end
      else if (clearing)
      begin
        clear_addr <= clear_addr + 1'b1;
        if (clear_addr == mem_addr_t'(MAX_CHANNELS - 1))
        begin
          clearing   <= 1'b0;
          clear_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (clearing)
      mem[clear_addr] <= '0;
    else if (inc_pending)
      mem[inc_addr] <= inc_value + count_t'(1);
    if (count_event)
    begin
      inc_addr  <= channel_index[ADDR_W-1:0];
      inc_value <= mem[channel_index[ADDR_W-1:0]];
    end
    read_count <= mem[read_index[ADDR_W-1:0]];
  end

  // the sequencer holds bursts back until the clear sweep is over
  a_no_event_in_clear: assert property (
    @(posedge aclk) disable iff (!areset_n) clearing |-> !count_event
  );

endmodule

// File: design/wb_spectrum_regs.sv
`timescale 1ns/100ps

module wb_spectrum_regs (
  input  logic                        aclk,
  input  logic                        areset_n,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic                        busy,
  input  logic                        done,
  input  mossbauer_pkg::wb_addr_t     wb_adr,
  input  mossbauer_pkg::wb_data_t     wb_dat_w,
  input  mossbauer_pkg::count_t       read_count,
  output logic                        wb_ack,
  output logic                        run_start,
  output logic                        clear_req,
  output mossbauer_pkg::wb_data_t     wb_dat_r,
  output mossbauer_pkg::impulse_cnt_t selection_count,
  output mossbauer_pkg::channel_t     channel_count,
  output mossbauer_pkg::sweep_cnt_t   sweep_count,
  output mossbauer_pkg::channel_t     read_index
);
  import mossbauer_pkg::*;

  wb_addr_t spectrum_offset;
  logic     in_window;
  logic     new_cycle;
  logic     cfg_write;

  assign spectrum_offset = wb_adr - SPECTRUM_BASE;
  assign in_window = (wb_adr >= SPECTRUM_BASE) &&
                     (spectrum_offset < wb_addr_t'(2 ** $bits(channel_t)));
  assign read_index = channel_t'(spectrum_offset);  // read_count is ready with ack
  assign new_cycle  = wb_cyc && wb_stb && !wb_ack;
  assign cfg_write  = new_cycle && wb_we && !busy;

  always_ff @(posedge aclk or negedge areset_n)
  begin
    if (!areset_n)
    begin
      wb_ack          <= 1'b0;
      run_start       <= 1'b0;
      clear_req       <= 1'b0;
      selection_count <= '0;
      channel_count   <= '0;
      sweep_count     <= '0;
    end
    else
    begin
      wb_ack    <= new_cycle;
      run_start <= 1'b0;
      clear_req <= 1'b0;
      if (cfg_write)
      begin
        case (wb_adr)
          ADDR_CTRL:
          begin
            run_start <= wb_dat_w[CTRL_START];
            clear_req <= wb_dat_w[CTRL_START] && wb_dat_w[CTRL_CLEAR];
          end
          ADDR_SELECTION: selection_count <= impulse_cnt_t'(wb_dat_w);
          ADDR_CHANNELS:  channel_count   <= channel_t'(wb_dat_w);
          ADDR_SWEEPS:    sweep_count     <= sweep_cnt_t'(wb_dat_w);
          default: ;
        endcase
      end
    end
  end

  always_comb
  begin
    wb_dat_r = '0;
    if (in_window)
      wb_dat_r = read_count;
    else
      case (wb_adr)
        ADDR_SELECTION: wb_dat_r = wb_data_t'(selection_count);
        ADDR_CHANNELS:  wb_dat_r = wb_data_t'(channel_count);
        ADDR_SWEEPS:    wb_dat_r = wb_data_t'(sweep_count);
        ADDR_STATUS:
        begin
          wb_dat_r[STATUS_BUSY] = busy;
          wb_dat_r[STATUS_DONE] = done;
        end
        default: wb_dat_r = '0;
      endcase
  end

  // the master keeps stb up until it sees ack
  a_ack_with_stb: assert property (
    @(posedge aclk) disable iff (!areset_n) wb_ack |-> wb_stb
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --x-initial 0 \
  --top-module tb_mossbauer -Mdir obj_dir -f tb.f \
  && ./obj_dir/Vtb_mossbauer | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }

// File: tb.f
design/mossbauer_pkg.sv
design/channel_sequencer.sv
design/discriminator_signal_gen.sv
design/diff_discriminator.sv
design/spectrum_accumulator.sv
design/wb_spectrum_regs.sv
design/mossbauer_spectrometer_top.sv
bench/tb_mossbauer.sv
